/* design/i2c_pkg.sv */
package i2c_pkg;

    // ------------------------------
    // register map
    // ------------------------------
    localparam int REG_SEL_W = 8;                           // taken from addr_i[23:16]

    localparam logic [REG_SEL_W-1:0] REG_SLAVE_ADDR = 8'h01;
    localparam logic [REG_SEL_W-1:0] REG_RDATA      = 8'h02;
    localparam logic [REG_SEL_W-1:0] REG_CMD        = 8'h03;
    localparam logic [REG_SEL_W-1:0] REG_STATUS     = 8'h04;

    localparam int DATA_W = 32;                             // processor bus
    localparam int WORD_W = 16;                             // sensor register word

    // command word layout: ptr in [31:30], rd in [29], write data in [15:0]
    localparam int CMD_PTR_LSB = 30;
    localparam int CMD_RD_BIT  = 29;

    // ------------------------------
    // shared types
    // ------------------------------
    typedef struct packed {
        logic [6:0]        slave_addr;
        logic              rd;                              // 1 = read transaction
        logic [1:0]        ptr;
        logic [WORD_W-1:0] wdata;
    } i2c_cmd_t;

    // one-cycle strobes from the scl divider
    typedef struct packed {
        logic sample;                                       // middle of scl high
        logic drive;                                        // middle of scl low
        logic fall;                                         // last cycle of scl high
    } i2c_tick_t;

    typedef enum logic {
        BYTE_TX = 1'b0,
        BYTE_RX = 1'b1
    } byte_dir_t;

endpackage

/* design/i2c_regs.sv */
`timescale 1ns/100ps

module i2c_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we_i,
    input  logic [31:0]                addr_i,
    input  logic [i2c_pkg::DATA_W-1:0] data_i,
    output logic [i2c_pkg::DATA_W-1:0] data_o,
    input  logic                       busy_i,
    input  logic [i2c_pkg::WORD_W-1:0] rdata_i,
    input  logic                       rdata_valid_i,
    output i2c_pkg::i2c_cmd_t          cmd_o,
    output logic                       start_o
);
    import i2c_pkg::*;

    logic [REG_SEL_W-1:0] reg_sel;
    logic [6:0]           slave_addr_q;
    logic [WORD_W-1:0]    rdata_q;
    logic                 cmd_wr;

    assign reg_sel = addr_i[16 +: REG_SEL_W];

    // a pending start counts as busy too
    assign cmd_wr = we_i && (reg_sel == REG_CMD) && !busy_i && !start_o;

    always_ff @(posedge clk) begin
        if (!rst) begin
            slave_addr_q <= '0;
            rdata_q      <= '0;
            start_o      <= 1'b0;
        end else begin
            start_o <= cmd_wr;                              // one-cycle kick
            if (we_i && (reg_sel == REG_SLAVE_ADDR)) begin
                slave_addr_q <= data_i[6:0];
            end
            if (rdata_valid_i) begin
                rdata_q <= rdata_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            cmd_o.slave_addr <= slave_addr_q;
            cmd_o.rd         <= data_i[CMD_RD_BIT];
            cmd_o.ptr        <= data_i[CMD_PTR_LSB +: 2];
            cmd_o.wdata      <= data_i[WORD_W-1:0];
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        case (reg_sel)
            REG_RDATA:  data_o = {{(DATA_W-WORD_W){1'b0}}, rdata_q};
            REG_STATUS: data_o = {{(DATA_W-1){1'b0}}, busy_i};
            default:    data_o = '0;
        endcase
    end

    // accepted command finds the sequencer idle, and it answers with busy
    assert property (@(posedge clk) disable iff (!rst) start_o |-> !busy_i ##1 busy_i);

endmodule

/* design/i2c_scl_gen.sv */
`timescale 1ns/100ps

module i2c_scl_gen #(
    parameter int CLK_DIV = 200
) (
    input  logic               clk,
    input  logic               rst,
    output i2c_pkg::i2c_tick_t tick_o,
    output logic               scl_o
);
    localparam int PH_W = $clog2(CLK_DIV);

    localparam logic [PH_W-1:0] PH_LAST = PH_W'(CLK_DIV - 1);
    localparam logic [PH_W-1:0] PH_QTR  = PH_W'(CLK_DIV / 4);
    localparam logic [PH_W-1:0] PH_HALF = PH_W'(CLK_DIV / 2);
    localparam logic [PH_W-1:0] PH_3QTR = PH_W'(3 * CLK_DIV / 4);

    logic [PH_W-1:0] phase_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase_q <= '0;
            scl_o   <= 1'b0;
        end else begin
            if (phase_q == PH_LAST) begin
                phase_q <= '0;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
            scl_o <= (phase_q < PH_HALF);                   // high over phases 1..HALF
        end
    end

    // ------------------------------
    // strobes
    // ------------------------------
    assign tick_o.sample = (phase_q == PH_QTR);
    assign tick_o.fall   = (phase_q == PH_HALF);
    assign tick_o.drive  = (phase_q == PH_3QTR);

    // quarter points must land on whole cycles
    assert property (@(posedge clk) (CLK_DIV % 4 == 0) && (CLK_DIV >= 8));

endmodule

/* design/i2c_byte_io.sv */
`timescale 1ns/100ps

module i2c_byte_io (
    input  logic               clk,
    input  logic               rst,
    input  i2c_pkg::i2c_tick_t tick_i,
    input  logic               byte_start_i,
    input  i2c_pkg::byte_dir_t dir_i,
    input  logic [7:0]         tx_byte_i,
    input  logic               ack_bit_i,
    input  logic               sda_i,
    output logic               byte_active_o,
    output logic               bit_sda_o,
    output logic               bit_oe_o,
    output logic [7:0]         rx_byte_o,
    output logic               byte_done_o
);
    import i2c_pkg::*;

    localparam logic [3:0] ACK_SLOT = 4'd8;

    byte_dir_t  dir_q;
    logic       ack_q;
    logic [7:0] shift_q;
    logic [3:0] slot_q;
    logic       active_q;
    logic       driven_q;                                   // first bit is on the line
    logic       shift_en;

    assign shift_en = active_q && driven_q && tick_i.sample && (slot_q != ACK_SLOT);

    always_ff @(posedge clk) begin
        if (!rst) begin
            active_q    <= 1'b0;
            driven_q    <= 1'b0;
            slot_q      <= '0;
            byte_done_o <= 1'b0;
            bit_sda_o   <= 1'b1;
            bit_oe_o    <= 1'b0;
        end else begin
            byte_done_o <= 1'b0;
            if (byte_start_i) begin
                active_q <= 1'b1;
                driven_q <= 1'b0;
                slot_q   <= '0;
            end else if (active_q) begin
                if (tick_i.drive) begin
                    driven_q <= 1'b1;
                    if (slot_q == ACK_SLOT) begin           // master acks only in RX
                        bit_oe_o  <= (dir_q == BYTE_RX);
                        bit_sda_o <= (dir_q == BYTE_RX) ? ack_q : 1'b1;
                    end else begin
                        bit_oe_o  <= (dir_q == BYTE_TX);
                        bit_sda_o <= (dir_q == BYTE_TX) ? shift_q[7] : 1'b1;
                    end
                end else if (tick_i.sample && driven_q) begin
                    if (slot_q == ACK_SLOT) begin
                        active_q    <= 1'b0;
                        byte_done_o <= 1'b1;
                    end else begin
                        slot_q <= slot_q + 1'b1;
                    end
                end
            end
        end
    end

    // msb first, rx bits enter at the bottom
    always_ff @(posedge clk) begin
        if (byte_start_i) begin
            dir_q   <= dir_i;
            ack_q   <= ack_bit_i;
            shift_q <= tx_byte_i;
        end else if (shift_en) begin
            shift_q <= {shift_q[6:0], sda_i};
        end
    end

    assign rx_byte_o     = shift_q;
    assign byte_active_o = (active_q && driven_q) || byte_done_o;   // pins owned here

    // sequencer must wait for byte_done before the next byte
    assert property (@(posedge clk) disable iff (!rst)
        byte_start_i |-> !active_q && !byte_done_o);

endmodule

/* design/i2c_ctrl_fsm.sv */
`timescale 1ns/100ps

module i2c_ctrl_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  i2c_pkg::i2c_tick_t         tick_i,
    input  logic                       start_i,
    input  i2c_pkg::i2c_cmd_t          cmd_i,
    input  logic                       byte_active_i,
    input  logic                       bit_sda_i,
    input  logic                       bit_oe_i,
    input  logic [7:0]                 rx_byte_i,
    input  logic                       byte_done_i,
    output logic                       byte_start_o,
    output i2c_pkg::byte_dir_t         dir_o,
    output logic [7:0]                 tx_byte_o,
    output logic                       ack_bit_o,
    output logic                       sda_o,
    output logic                       sda_oe_o,
    output logic                       busy_o,
    output logic [i2c_pkg::WORD_W-1:0] rdata_o,
    output logic                       rdata_valid_o
);
    import i2c_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        START,
        ADDR,
        PTR,
        RESTART,
        ADDR_RD,
        RD_HI,
        RD_LO,
        WR_HI,
        WR_LO,
        STOP
    } state_t;

    state_t     state_q;
    logic [1:0] step_q;                                     // sub-step of START/RESTART/STOP
    logic       sda_q;
    logic       oe_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q       <= IDLE;
            step_q        <= '0;
            sda_q         <= 1'b1;
            oe_q          <= 1'b1;
            busy_o        <= 1'b0;
            byte_start_o  <= 1'b0;
            rdata_valid_o <= 1'b0;
        end else begin
            byte_start_o  <= 1'b0;
            rdata_valid_o <= 1'b0;
            if (byte_done_i) begin
                sda_q <= bit_sda_i;                         // keep the line where the ack left it
                oe_q  <= bit_oe_i;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        busy_o  <= 1'b1;
                        step_q  <= '0;
                        state_q <= START;
                    end
                end
                // ------------------------------
                // start and repeated start
                // ------------------------------
                START, RESTART: begin
                    if (step_q == 2'd0 && tick_i.drive) begin
                        sda_q  <= 1'b1;                     // release while scl low
                        oe_q   <= 1'b1;
                        step_q <= 2'd1;
                    end else if (step_q == 2'd1 && tick_i.sample) begin
                        sda_q        <= 1'b0;               // falling sda, scl high
                        step_q       <= '0;
                        byte_start_o <= 1'b1;
                        state_q      <= (state_q == START) ? ADDR : ADDR_RD;
                    end
                end
                // ------------------------------
                // byte sequence
                // ------------------------------
                ADDR: begin
                    if (byte_done_i) begin
                        byte_start_o <= 1'b1;
                        state_q      <= PTR;
                    end
                end
                PTR: begin
                    if (byte_done_i) begin
                        if (cmd_i.rd) begin
                            step_q  <= '0;
                            state_q <= RESTART;
                        end else begin
                            byte_start_o <= 1'b1;
                            state_q      <= WR_HI;
                        end
                    end
                end
                ADDR_RD: begin
                    if (byte_done_i) begin
                        byte_start_o <= 1'b1;
                        state_q      <= RD_HI;
                    end
                end
                RD_HI: begin
                    if (byte_done_i) begin
                        byte_start_o <= 1'b1;
                        state_q      <= RD_LO;
                    end
                end
                RD_LO: begin
                    if (byte_done_i) begin
                        rdata_valid_o <= 1'b1;
                        step_q        <= '0;
                        state_q       <= STOP;
                    end
                end
                WR_HI: begin
                    if (byte_done_i) begin
                        byte_start_o <= 1'b1;
                        state_q      <= WR_LO;
                    end
                end
                WR_LO: begin
                    if (byte_done_i) begin
                        step_q  <= '0;
                        state_q <= STOP;
                    end
                end
                STOP: begin
                    if (step_q == 2'd0 && tick_i.drive) begin
                        sda_q  <= 1'b0;
                        oe_q   <= 1'b1;
                        step_q <= 2'd1;
                    end else if (step_q == 2'd1 && tick_i.sample) begin
                        sda_q  <= 1'b1;                     // rising sda, scl high
                        step_q <= 2'd2;
                    end else if (step_q == 2'd2 && tick_i.fall) begin
                        busy_o  <= 1'b0;                    // bus free after half a period
                        step_q  <= '0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // received word, high byte first
    always_ff @(posedge clk) begin
        if (byte_done_i && state_q == RD_HI) begin
            rdata_o[15:8] <= rx_byte_i;
        end
        if (byte_done_i && state_q == RD_LO) begin
            rdata_o[7:0] <= rx_byte_i;
        end
    end

    // byte payload follows the state it is launched in
    always_comb begin
        dir_o     = BYTE_TX;
        ack_bit_o = 1'b1;
        tx_byte_o = 8'hff;
        case (state_q)
            ADDR:    tx_byte_o = {cmd_i.slave_addr, 1'b0};
            PTR:     tx_byte_o = {6'b0, cmd_i.ptr};
            ADDR_RD: tx_byte_o = {cmd_i.slave_addr, 1'b1};
            WR_HI:   tx_byte_o = cmd_i.wdata[15:8];
            WR_LO:   tx_byte_o = cmd_i.wdata[7:0];
            RD_HI: begin
                dir_o     = BYTE_RX;
                ack_bit_o = 1'b0;                           // ack, more to come
            end
            RD_LO:   dir_o = BYTE_RX;                       // nack on the last byte
            default: ;
        endcase
    end

    assign sda_o    = byte_active_i ? bit_sda_i : sda_q;
    assign sda_oe_o = byte_active_i ? bit_oe_i  : oe_q;

endmodule

/* design/i2c_master_top.sv */
`timescale 1ns/100ps

module i2c_master_top #(
    parameter int CLK_DIV = 200
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we_i,
    input  logic [31:0]                addr_i,
    input  logic [i2c_pkg::DATA_W-1:0] data_i,
    output logic [i2c_pkg::DATA_W-1:0] data_o,
    output logic                       scl_o,
    output logic                       sda_o,
    output logic                       sda_oe_o,
    input  logic                       sda_i
);
    import i2c_pkg::*;

    i2c_cmd_t    cmd;
    i2c_tick_t   tick;
    byte_dir_t   dir;
    logic        start;
    logic        busy;
    logic [WORD_W-1:0] rdata;
    logic        rdata_valid;
    logic        byte_start;
    logic [7:0]  tx_byte;
    logic        ack_bit;
    logic        byte_active;
    logic        bit_sda;
    logic        bit_oe;
    logic [7:0]  rx_byte;
    logic        byte_done;

    i2c_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .we_i          (we_i),
        .addr_i        (addr_i),
        .data_i        (data_i),
        .data_o        (data_o),
        .busy_i        (busy),
        .rdata_i       (rdata),
        .rdata_valid_i (rdata_valid),
        .cmd_o         (cmd),
        .start_o       (start)
    );

    i2c_scl_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_scl_gen (
        .clk    (clk),
        .rst    (rst),
        .tick_o (tick),
        .scl_o  (scl_o)
    );

    // sequencer owns the pins, byte engine lends it bits
    i2c_ctrl_fsm u_ctrl_fsm (
        .clk           (clk),
        .rst           (rst),
        .tick_i        (tick),
        .start_i       (start),
        .cmd_i         (cmd),
        .byte_active_i (byte_active),
        .bit_sda_i     (bit_sda),
        .bit_oe_i      (bit_oe),
        .rx_byte_i     (rx_byte),
        .byte_done_i   (byte_done),
        .byte_start_o  (byte_start),
        .dir_o         (dir),
        .tx_byte_o     (tx_byte),
        .ack_bit_o     (ack_bit),
        .sda_o         (sda_o),
        .sda_oe_o      (sda_oe_o),
        .busy_o        (busy),
        .rdata_o       (rdata),
        .rdata_valid_o (rdata_valid)
    );

    i2c_byte_io u_byte_io (
        .clk           (clk),
        .rst           (rst),
        .tick_i        (tick),
        .byte_start_i  (byte_start),
        .dir_i         (dir),
        .tx_byte_i     (tx_byte),
        .ack_bit_i     (ack_bit),
        .sda_i         (sda_i),
        .byte_active_o (byte_active),
        .bit_sda_o     (bit_sda),
        .bit_oe_o      (bit_oe),
        .rx_byte_o     (rx_byte),
        .byte_done_o   (byte_done)
    );

endmodule

/* dv/i2c_slave_model.sv */
`timescale 1ns/100ps

module i2c_slave_model (
    input  logic       clk,
    input  logic       rst,
    input  logic       scl_i,
    input  logic       sda_i,
    output logic       sda_o,                               // 0 pulls the line low
    output logic [7:0] rx_byte_o,
    output logic       rx_valid_o
);
    logic [15:0] regs_q [4];
    logic        scl_q;
    logic        sda_q;
    logic        active_q;                                  // between start and stop
    logic        reading_q;                                 // slave is sending
    logic        in_ack_q;                                  // ninth clock of a byte
    logic        rd_req_q;
    logic        mack_q;                                    // master acked last byte
    logic [3:0]  bit_cnt_q;
    logic [2:0]  byte_cnt_q;
    logic [7:0]  shift_q;
    logic [7:0]  tx_q;
    logic [1:0]  ptr_q;
    logic [7:0]  hi_q;
    logic        scl_rise;
    logic        scl_fall;
    logic        start_cond;
    logic        stop_cond;

    assign scl_rise   = scl_i && !scl_q;
    assign scl_fall   = !scl_i && scl_q;
    assign start_cond = scl_i && scl_q && sda_q && !sda_i;
    assign stop_cond  = scl_i && scl_q && !sda_q && sda_i;

    // line sampled mid-cycle, away from the dut clock edge
    always @(negedge clk) begin
        scl_q      <= scl_i;
        sda_q      <= sda_i;
        rx_valid_o <= 1'b0;
        if (!rst) begin
            active_q   <= 1'b0;
            reading_q  <= 1'b0;
            in_ack_q   <= 1'b0;
            rd_req_q   <= 1'b0;
            mack_q     <= 1'b0;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            ptr_q      <= '0;
            sda_o      <= 1'b1;
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (start_cond) begin                      // also repeated start
            active_q   <= 1'b1;
            reading_q  <= 1'b0;
            in_ack_q   <= 1'b0;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            sda_o      <= 1'b1;
        end else if (stop_cond) begin
            active_q  <= 1'b0;
            reading_q <= 1'b0;
            in_ack_q  <= 1'b0;
            sda_o     <= 1'b1;
        end else if (active_q && scl_rise) begin
            if (in_ack_q) begin
                mack_q <= !sda_i;
            end else begin
                if (!reading_q) begin
                    shift_q <= {shift_q[6:0], sda_i};
                end
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else if (active_q && scl_fall) begin
            if (in_ack_q) begin
                // ------------------------------
                // end of ack clock
                // ------------------------------
                in_ack_q  <= 1'b0;
                bit_cnt_q <= '0;
                if (!reading_q && rd_req_q) begin
                    reading_q <= 1'b1;
                    rd_req_q  <= 1'b0;
                    tx_q      <= regs_q[ptr_q][15:8];
                    sda_o     <= regs_q[ptr_q][15];
                end else if (reading_q && mack_q) begin
                    tx_q  <= regs_q[ptr_q][7:0];            // low byte follows
                    sda_o <= regs_q[ptr_q][7];
                end else begin
                    sda_o <= 1'b1;
                end
            end else if (bit_cnt_q == 4'd8) begin
                in_ack_q <= 1'b1;
                if (reading_q) begin
                    sda_o <= 1'b1;                          // master answers
                end else begin
                    sda_o      <= 1'b0;                     // ack every byte
                    rx_byte_o  <= shift_q;
                    rx_valid_o <= 1'b1;
                    byte_cnt_q <= byte_cnt_q + 3'd1;
                    case (byte_cnt_q)
                        3'd0:    rd_req_q <= shift_q[0];
                        3'd1:    ptr_q <= shift_q[1:0];
                        3'd2:    hi_q <= shift_q;
                        3'd3:    regs_q[ptr_q] <= {hi_q, shift_q};
                        default: ;
                    endcase
                end
            end else if (reading_q) begin
                sda_o <= tx_q[3'(7 - bit_cnt_q)];
            end
        end
    end

endmodule

/* dv/tb_i2c_master.sv */
`timescale 1ns/100ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int         CLK_DIV     = 16;
    localparam int         CLK_PERIOD  = 4;
    localparam int         NUM_RAND    = 40;
    localparam int         NUM_TXN     = NUM_RAND + 3;
    localparam int         TXN_CYCLES  = 5 * 9 * CLK_DIV;
    localparam int         WATCHDOG_NS = NUM_TXN * (TXN_CYCLES + 10 * CLK_DIV) * CLK_PERIOD + 2000;
    localparam logic [6:0] SLV_ADDR    = 7'h48;
    localparam int         SEED        = 32'h4b283d93;

    logic              clk;
    logic              rst;
    logic              we_i;
    logic [31:0]       addr_i;
    logic [DATA_W-1:0] data_i;
    logic [DATA_W-1:0] data_o;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    logic              sda_line;
    logic              slave_sda;
    logic [7:0]        slave_rx_byte;
    logic              slave_rx_valid;

    logic [7:0]        log_q [$];
    logic [15:0]       ref_mem [4];
    string             name_q [$];
    logic [63:0]       exp_q [$];
    logic [63:0]       act_q [$];
    int                pass_cnt;
    int                fail_cnt;
    int                other_errs;
    int                seed;

    // both sides of the open drain line can only pull low
    assign sda_line = (sda_oe ? sda_out : 1'b1) & slave_sda;

    i2c_master_top #(
        .CLK_DIV (CLK_DIV)
    ) i2c_master_top_i (
        .clk      (clk),
        .rst      (rst),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .data_i   (data_i),
        .data_o   (data_o),
        .scl_o    (scl),
        .sda_o    (sda_out),
        .sda_oe_o (sda_oe),
        .sda_i    (sda_line)
    );

    i2c_slave_model u_slave (
        .clk        (clk),
        .rst        (rst),
        .scl_i      (scl),
        .sda_i      (sda_line),
        .sda_o      (slave_sda),
        .rx_byte_o  (slave_rx_byte),
        .rx_valid_o (slave_rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (slave_rx_valid) begin
            log_q.push_back(slave_rx_byte);
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [15:0] expected_word(input logic [1:0] ptr);
        return ref_mem[ptr];
    endfunction

    function automatic logic [31:0] cmd_word(input logic [1:0] ptr, input logic rd,
                                             input logic [15:0] wdata);
        return {ptr, rd, 13'd0, wdata};
    endfunction

    // byte count above the first four logged bytes with the first byte highest
    function automatic logic [63:0] pack_log();
        logic [31:0] bytes;
        bytes = '0;
        for (int i = 0; i < 4; i++) begin
            if (i < log_q.size()) begin
                bytes[31-8*i -: 8] = log_q[i];
            end
        end
        return {32'(log_q.size()), bytes};
    endfunction

    task automatic expect_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        name_q.push_back(name);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endtask

    task automatic reg_write(input logic [7:0] sel, input logic [31:0] value);
        @(posedge clk);
        we_i   <= 1'b1;
        addr_i <= {8'h00, sel, 16'h0000};
        data_i <= value;
        @(posedge clk);
        we_i   <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] sel, output logic [31:0] value);
        @(posedge clk);
        addr_i <= {8'h00, sel, 16'h0000};
        @(negedge clk);
        value = data_o;                                     // combinational read
    endtask

    task automatic wait_status(input logic level, input int limit, input string name);
        logic [31:0] st;
        int          cycles;
        cycles = 0;
        reg_read(REG_STATUS, st);
        while (st[0] != level && cycles < limit) begin
            reg_read(REG_STATUS, st);
            cycles++;
        end
        if (st[0] != level) begin
            $display("%s: busy did not go to %0d within %0d cycles", name, level, limit);
            other_errs++;
        end
    endtask

    task automatic run_txn(input logic [1:0] ptr, input logic rd, input logic [15:0] wdata,
                           input string name);
        log_q.delete();
        reg_write(REG_CMD, cmd_word(ptr, rd, wdata));
        wait_status(1'b1, 8, name);
        wait_status(1'b0, 2 * TXN_CYCLES, name);
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin : stimulus
        logic [31:0] rd_val;
        logic [1:0]  ptr;
        logic [15:0] wdata;
        logic        rd;
        rst        = 1'b0;
        we_i       = 1'b0;
        addr_i     = '0;
        data_i     = '0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        other_errs = 0;
        seed       = SEED;
        for (int i = 0; i < 4; i++) begin
            ref_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        // scl low, sda driven high while in reset
        expect_value("reset_pins", 64'd3, {61'd0, scl, sda_out, sda_oe});
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        reg_read(REG_STATUS, rd_val);
        expect_value("reset_status", 64'd0, {32'd0, rd_val});
        reg_read(REG_RDATA, rd_val);
        expect_value("reset_rdata", 64'd0, {32'd0, rd_val});

        reg_write(REG_SLAVE_ADDR, {25'd0, SLV_ADDR});

        // write logs address, pointer, high and low byte
        run_txn(2'd1, 1'b0, 16'hbeef, "write_txn");
        ref_mem[1] = 16'hbeef;
        expect_value("write_log", {32'd4, SLV_ADDR, 1'b0, 8'h01, 8'hbe, 8'hef}, pack_log());
        reg_read(REG_STATUS, rd_val);
        expect_value("write_busy_low", 64'd0, {32'd0, rd_val});

        // read logs address, pointer and address with r
        run_txn(2'd1, 1'b1, 16'h0000, "read_txn");
        expect_value("read_log", {32'd3, SLV_ADDR, 1'b0, 8'h01, SLV_ADDR, 1'b1, 8'h00},
                     pack_log());
        reg_read(REG_RDATA, rd_val);
        expect_value("read_rdata", {48'd0, expected_word(2'd1)}, {32'd0, rd_val});

        // second command lands while the first runs
        log_q.delete();
        reg_write(REG_CMD, cmd_word(2'd2, 1'b0, 16'h1234));
        wait_status(1'b1, 8, "busy_drop");
        reg_write(REG_CMD, cmd_word(2'd3, 1'b1, 16'h0000));
        wait_status(1'b0, 2 * TXN_CYCLES, "busy_drop");
        ref_mem[2] = 16'h1234;
        repeat (4 * CLK_DIV) @(posedge clk);
        expect_value("busy_drop_log", {32'd4, SLV_ADDR, 1'b0, 8'h02, 8'h12, 8'h34}, pack_log());
        reg_read(REG_STATUS, rd_val);
        expect_value("busy_drop_idle", 64'd0, {32'd0, rd_val});

        for (int i = 0; i < NUM_RAND; i++) begin
            ptr   = 2'($random(seed));
            wdata = 16'($random(seed));
            rd    = 1'($random(seed));
            run_txn(ptr, rd, wdata, $sformatf("rand_%0d", i));
            if (rd) begin
                reg_read(REG_RDATA, rd_val);
                expect_value($sformatf("rand_%0d_read_p%0d", i, ptr),
                             {48'd0, expected_word(ptr)}, {32'd0, rd_val});
            end else begin
                ref_mem[ptr] = wdata;
            end
        end

        while (name_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("checks: %0d passed, %0d failed, %0d other errors",
                 pass_cnt, fail_cnt, other_errs);
        if (fail_cnt == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ------------------------------
    // compare
    // ------------------------------
    initial begin : compare
        string       name;
        logic [63:0] exp_v;
        logic [63:0] act_v;
        forever begin
            @(posedge clk);
            while (name_q.size() > 0) begin
                name  = name_q.pop_front();
                exp_v = exp_q.pop_front();
                act_v = act_q.pop_front();
                if (act_v !== exp_v) begin
                    $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
                    fail_cnt++;
                end else begin
                    $display("ok %s value %h", name, act_v);
                    pass_cnt++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a transaction never finished", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* i2c_master_top.f */
design/i2c_pkg.sv
design/i2c_regs.sv
design/i2c_scl_gen.sv
design/i2c_byte_io.sv
design/i2c_ctrl_fsm.sv
design/i2c_master_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_master.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f i2c_master_top.f \
    --top-module tb_i2c_master --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi

exit 0
